// File: flist.f
+incdir+include
logic/bombPkg.sv
logic/joystickDecoder.sv
logic/bombFuse.sv
logic/playerUnit.sv
logic/pixelMixer.sv
logic/bombGameTop.sv
tb/bombGame_chk.sv
tb/bombGameTb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run bombGameTb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f flist.f --top-module bombGameTb -Mdir obj_dir
	./obj_dir/VbombGameTb +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/bombGameTb.sv
`default_nettype none
`include "bomb_macros.svh"

module bombGameTb import bombPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_SIZE = `AVATAR_HALF;
	localparam int STEP_SIZE = `STEP;
	localparam int FUSE_LEN = `FUSE_TICKS;
	localparam int BLAST_LEN = `BLAST_TICKS;

	localparam coordT BLOCK_X_LO [4] = '{`BLOCK_X0_LO, `BLOCK_X1_LO, `BLOCK_X2_LO, `BLOCK_X3_LO};
	localparam coordT BLOCK_X_HI [4] = '{`BLOCK_X0_HI, `BLOCK_X1_HI, `BLOCK_X2_HI, `BLOCK_X3_HI};
	localparam coordT BLOCK_Y_LO [4] = '{`BLOCK_Y0_LO, `BLOCK_Y1_LO, `BLOCK_Y2_LO, `BLOCK_Y3_LO};
	localparam coordT BLOCK_Y_HI [4] = '{`BLOCK_Y0_HI, `BLOCK_Y1_HI, `BLOCK_Y2_HI, `BLOCK_Y3_HI};
	localparam coordT KEEP_X_LO [4] = '{`KEEP_X0_LO, `KEEP_X1_LO, `KEEP_X2_LO, `KEEP_X3_LO};
	localparam coordT KEEP_X_HI [4] = '{`KEEP_X0_HI, `KEEP_X1_HI, `KEEP_X2_HI, `KEEP_X3_HI};
	localparam coordT SNAP_LEFT [4] = '{`SNAP_LEFT0, `SNAP_LEFT1, `SNAP_LEFT2, `SNAP_LEFT3};

	localparam stickInT STICK_UP = '{stickX: 10'd500, stickY: 10'd900, bombButton: 1'b0};
	localparam stickInT STICK_LEFT = '{stickX: 10'd100, stickY: 10'd500, bombButton: 1'b0};
	localparam stickInT STICK_RIGHT = '{stickX: 10'd900, stickY: 10'd500, bombButton: 1'b0};
	localparam stickInT STICK_DROP = '{stickX: 10'd500, stickY: 10'd500, bombButton: 1'b1};

	logic DIV_CLK;
	logic reset;
	logic gameTick;
	stickInT sticks [2];
	pixelT pixel;
	logic vgaR;
	logic vgaG;
	logic vgaB;

	int errors;
	int checks;
	logic [15:0] lfsr;
	int p0X;
	int p0Y;
	int p1X;
	int p1Y;

	bombGameTop bombGameTop_i (
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.gameTick(gameTick),
		.sticks(sticks),
		.pixel(pixel),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB)
	);

	bind bombGameTop bombGame_chk bombGame_chk_i (
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.pixel(pixel),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB),
		.fuseState0(gPlayer[0].playerUnit_i.bombFuse_i.state),
		.fuseState1(gPlayer[1].playerUnit_i.bombFuse_i.state),
		.posX0(gPlayer[0].playerUnit_i.posX),
		.posY0(gPlayer[0].playerUnit_i.posY),
		.posX1(gPlayer[1].playerUnit_i.posX),
		.posY1(gPlayer[1].playerUnit_i.posY)
	);

	initial
	begin
		DIV_CLK = 1'b0;
		forever
			#10 DIV_CLK = ~DIV_CLK;
	end

	////////////////////////////////////////
	// Stimulus helpers

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic nextBit();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 16'hB400;
		return outBit;
	endfunction

	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
			value = {value[14:0], nextBit()};
		return value;
	endfunction

	// Both axes inside 300..700 and no button
	function automatic stickInT neutralStick();
		stickInT s;
		s.stickX = stickT'(16'd300 + randomBits(9) % 16'd401);
		s.stickY = stickT'(16'd300 + randomBits(9) % 16'd401);
		s.bombButton = 1'b0;
		return s;
	endfunction

	// Frame or maze block
	function automatic logic mazeGreen(input int x, input int y);
		logic inCol;
		logic inRow;
		logic border;
		inCol = 1'b0;
		inRow = 1'b0;
		for (int k = 0; k < 4; k++)
		begin
			inCol = inCol || (x >= int'(BLOCK_X_LO[k]) && x <= int'(BLOCK_X_HI[k]));
			inRow = inRow || (y >= int'(BLOCK_Y_LO[k]) && y <= int'(BLOCK_Y_HI[k]));
		end
		border = (x <= int'(`WALL_X)) || (x >= 640 - int'(`WALL_X))
			|| (y <= int'(`WALL_Y)) || (y >= 480 - int'(`WALL_Y));
		return border || (inCol && inRow);
	endfunction

	function automatic logic nearAvatar(input int x, input int y, input int cx, input int cy);
		return (x >= cx - HALF_SIZE) && (x <= cx + HALF_SIZE)
			&& (y >= cy - HALF_SIZE) && (y <= cy + HALF_SIZE);
	endfunction

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Error: %0t ns %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// Colour appears one cycle after the pixel
	task automatic probe(input coordT x, input coordT y, input logic active,
			output logic r, output logic g, output logic b);
		@(posedge DIV_CLK);
		pixel <= '{x: x, y: y, active: active};
		@(posedge DIV_CLK);
		@(negedge DIV_CLK);
		r = vgaR;
		g = vgaG;
		b = vgaB;
	endtask

	task automatic gameStep(input stickInT s0, input stickInT s1);
		@(posedge DIV_CLK);
		sticks[0] <= s0;
		sticks[1] <= s1;
		gameTick <= 1'b1;
		@(posedge DIV_CLK);
		gameTick <= 1'b0;
	endtask

	task automatic finishTest(input string name, input int startErrors);
		$display("%s: %0d errors", name, errors - startErrors);
	endtask

	// Red exactly out to the half size on each side
	task automatic avatarEdges(input int cx, input int cy);
		int px;
		int py;
		logic r;
		logic g;
		logic b;
		for (int side = 0; side < 4; side++)
		begin
			for (int reach = HALF_SIZE; reach <= HALF_SIZE + 1; reach++)
			begin
				px = cx + ((side == 0) ? -reach : (side == 1) ? reach : 0);
				py = cy + ((side == 2) ? -reach : (side == 3) ? reach : 0);
				probe(coordT'(px), coordT'(py), 1'b1, r, g, b);
				checkBit("vgaR", r, reach == HALF_SIZE);
				if (reach != HALF_SIZE)
					checkBit("vgaG", g, mazeGreen(px, py));
			end
		end
	endtask

	////////////////////////////////////////
	// Directed tests

	task automatic mazeColours();
		int startErrors;
		int probed;
		int x;
		int y;
		logic r;
		logic g;
		logic b;
		startErrors = errors;
		probed = 0;
		@(posedge DIV_CLK);
		sticks[0] <= neutralStick();
		sticks[1] <= neutralStick();
		for (int n = 0; n < 200 && probed < 40; n++)
		begin
			x = int'(randomBits(10) % 16'd640);
			y = int'(randomBits(9) % 16'd480);
			if (!nearAvatar(x, y, p0X, p0Y) && !nearAvatar(x, y, p1X, p1Y))
			begin
				probe(coordT'(x), coordT'(y), 1'b1, r, g, b);
				checkBit("vgaR", r, 1'b0);
				checkBit("vgaG", g, mazeGreen(x, y));
				checkBit("vgaB", b, 1'b0);
				probed++;
			end
		end
		// Wall pixel outside the display area
		probe(10'd300, 10'd3, 1'b0, r, g, b);
		checkBit("vgaR", r, 1'b0);
		checkBit("vgaG", g, 1'b0);
		checkBit("vgaB", b, 1'b0);
		finishTest("maze colours", startErrors);
	endtask

	task automatic moveAlongTop();
		int startErrors;
		startErrors = errors;
		// Start point lies outside the arena
		gameStep(neutralStick(), neutralStick());
		p0X = `ARENA_MIN_X;
		p0Y = `ARENA_MIN_Y;
		avatarEdges(p0X, p0Y);
		for (int n = 0; n < 10; n++)
		begin
			gameStep(STICK_RIGHT, neutralStick());
			p0X = p0X + STEP_SIZE;
		end
		avatarEdges(p0X, p0Y);
		finishTest("move along top", startErrors);
	endtask

	task automatic snapAtBlock();
		int startErrors;
		int nextX;
		logic snapped;
		startErrors = errors;
		snapped = 1'b0;
		// Climb into the third keep-out row while x 600 stays clear of the columns
		for (int n = 0; n < 50; n++)
		begin
			gameStep(neutralStick(), STICK_UP);
			p1Y = p1Y - STEP_SIZE;
		end
		avatarEdges(p1X, p1Y);
		for (int n = 0; n < 60 && !snapped; n++)
		begin
			gameStep(neutralStick(), STICK_LEFT);
			nextX = p1X - STEP_SIZE;
			p1X = nextX;
			for (int k = 0; k < 4; k++)
			begin
				if (nextX > int'(KEEP_X_LO[k]) && nextX < int'(KEEP_X_HI[k]))
				begin
					p1X = SNAP_LEFT[k];
					snapped = 1'b1;
				end
			end
		end
		avatarEdges(p1X, p1Y);
		for (int n = 0; n < 3; n++)
			gameStep(neutralStick(), STICK_LEFT);
		avatarEdges(p1X, p1Y);
		finishTest("snap at block", startErrors);
	endtask

	// One bomb from player 0 with an optional second press mid fuse
	task automatic bombFuseCycle(input logic redrop);
		int bombX;
		int bombY;
		logic visible;
		logic inBlast;
		logic colBand;
		logic r;
		logic g;
		logic b;
		bombX = p0X;
		bombY = p0Y;
		colBand = (bombX >= int'(`BAND_COL0_LO)) && (bombX <= int'(`BAND_COL0_HI));
		gameStep(STICK_DROP, neutralStick());
		for (int i = 1; i <= FUSE_LEN + BLAST_LEN; i++)
		begin
			if (i <= 12)
			begin
				gameStep(STICK_RIGHT, neutralStick());
				p0X = p0X + STEP_SIZE;
			end
			else if (redrop && i == 50)
				gameStep(STICK_DROP, neutralStick());
			else
				gameStep(neutralStick(), neutralStick());
			inBlast = (i >= FUSE_LEN) && (i < FUSE_LEN + BLAST_LEN);
			if (i < FUSE_LEN)
			begin
				visible = ((FUSE_LEN - i) & 8) == 0;
				probe(coordT'(bombX), coordT'(bombY), 1'b1, r, g, b);
				checkBit("vgaB", b, visible);
				checkBit("vgaR", r, visible || nearAvatar(bombX, bombY, p0X, p0Y));
			end
			probe(10'd300, coordT'(bombY + 3), 1'b1, r, g, b);
			checkBit("vgaR", r, inBlast);
			checkBit("vgaB", b, inBlast);
			probe(10'd30, 10'd300, 1'b1, r, g, b);
			checkBit("vgaR", r, inBlast && colBand);
			checkBit("vgaB", b, inBlast && colBand);
		end
	endtask

	task automatic bombDrop();
		int startErrors;
		startErrors = errors;
		bombFuseCycle(1'b0);
		finishTest("bomb drop", startErrors);
	endtask

	task automatic bombRedrop();
		int startErrors;
		startErrors = errors;
		bombFuseCycle(1'b1);
		bombFuseCycle(1'b0);
		finishTest("bomb redrop", startErrors);
	endtask

	////////////////////////////////////////
	// Main sequence

	initial
	begin
		errors = 0;
		checks = 0;
		lfsr = 16'd53;
		p0X = `P0_START_X;
		p0Y = `P0_START_Y;
		p1X = `P1_START_X;
		p1Y = `P1_START_Y;
		reset = 1'b1;
		gameTick = 1'b0;
		sticks[0] = '{stickX: 10'd500, stickY: 10'd500, bombButton: 1'b0};
		sticks[1] = '{stickX: 10'd500, stickY: 10'd500, bombButton: 1'b0};
		pixel = '{x: 10'd0, y: 10'd0, active: 1'b0};
		repeat (10)
			@(posedge DIV_CLK);
		reset <= 1'b0;

		mazeColours();
		moveAlongTop();
		snapAtBlock();
		bombDrop();
		bombRedrop();

		repeat (2)
			@(posedge DIV_CLK);
		errors = errors + bombGameTop_i.bombGame_chk_i.failCount;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/bombGame_chk.sv
`default_nettype none
`include "bomb_macros.svh"

module bombGame_chk import bombPkg::*; (
	input wire logic DIV_CLK,
	input wire logic reset,
	input wire pixelT pixel,
	input wire logic vgaR,
	input wire logic vgaG,
	input wire logic vgaB,
	input wire fuseStateT fuseState0,
	input wire fuseStateT fuseState1,
	input wire coordT posX0,
	input wire coordT posY0,
	input wire coordT posX1,
	input wire coordT posY1
);

	timeunit 1ns;
	timeprecision 1ps;

	int failCount;

	initial
		failCount = 0;

	// Outside the display area the next colour is black
	blankOutside: assert property (@(posedge DIV_CLK) disable iff (reset)
		!pixel.active |=> !vgaR && !vgaG && !vgaB)
	else
	begin
		failCount++;
		$error("colour output set after an inactive pixel");
	end

	////////////////////////////////////////
	// Fuse state machines
	// Phases only advance IDLE to FUSE to BLAST and back to IDLE

	fuseLegal0: assert property (@(posedge DIV_CLK) disable iff (reset)
		(fuseState0 != $past(fuseState0)) |->
			(($past(fuseState0) == IDLE) && (fuseState0 == FUSE))
			|| (($past(fuseState0) == FUSE) && (fuseState0 == BLAST))
			|| (($past(fuseState0) == BLAST) && (fuseState0 == IDLE)))
	else
	begin
		failCount++;
		$error("player 0 fuse state took an illegal step");
	end

	fuseLegal1: assert property (@(posedge DIV_CLK) disable iff (reset)
		(fuseState1 != $past(fuseState1)) |->
			(($past(fuseState1) == IDLE) && (fuseState1 == FUSE))
			|| (($past(fuseState1) == FUSE) && (fuseState1 == BLAST))
			|| (($past(fuseState1) == BLAST) && (fuseState1 == IDLE)))
	else
	begin
		failCount++;
		$error("player 1 fuse state took an illegal step");
	end

	////////////////////////////////////////
	// Positions stay on screen

	posOnScreen0: assert property (@(posedge DIV_CLK) disable iff (reset)
		(posX0 < `SCREEN_W) && (posY0 < `SCREEN_H))
	else
	begin
		failCount++;
		$error("player 0 position left the screen");
	end

	posOnScreen1: assert property (@(posedge DIV_CLK) disable iff (reset)
		(posX1 < `SCREEN_W) && (posY1 < `SCREEN_H))
	else
	begin
		failCount++;
		$error("player 1 position left the screen");
	end

endmodule

`default_nettype wire

// File: logic/bombGameTop.sv
`default_nettype none

module bombGameTop import bombPkg::*; (
	input wire logic DIV_CLK,
	input wire logic reset,
	input wire logic gameTick,
	input wire stickInT sticks [2],
	input wire pixelT pixel,
	output logic vgaR,
	output logic vgaG,
	output logic vgaB
);

	moveCmdT cmds [2];
	playerHitsT hits [2];

	joystickDecoder joystickDecoder_i (
		.sticks(sticks),
		.cmds(cmds)
	);

	// Player 0 is red, player 1 is yellow
	for (genvar p = 0; p < 2; p++)
	begin : gPlayer
		playerUnit #(
			.playerIndex(p)
		) playerUnit_i (
			.DIV_CLK(DIV_CLK),
			.reset(reset),
			.gameTick(gameTick),
			.cmd(cmds[p]),
			.pixel(pixel),
			.hits(hits[p])
		);
	end

	pixelMixer pixelMixer_i (
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.pixel(pixel),
		.hits(hits),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB)
	);

endmodule

`default_nettype wire

// File: logic/pixelMixer.sv
`default_nettype none
`include "bomb_macros.svh"

module pixelMixer import bombPkg::*; (
	input wire logic DIV_CLK,
	input wire logic reset,
	input wire pixelT pixel,
	input wire playerHitsT hits [2],
	output logic vgaR,
	output logic vgaG,
	output logic vgaB
);

	logic wall;
	logic blockCol;
	logic blockRow;
	logic red;
	logic green;
	logic blue;

	// Outer frame, right and bottom edges run to the screen size
	assign wall = (pixel.x <= `WALL_X) || (pixel.x >= `SCREEN_W - `WALL_X)
		|| (pixel.y <= `WALL_Y) || (pixel.y >= `SCREEN_H - `WALL_Y);

	assign blockCol = inRange(pixel.x, `BLOCK_X0_LO, `BLOCK_X0_HI)
		|| inRange(pixel.x, `BLOCK_X1_LO, `BLOCK_X1_HI)
		|| inRange(pixel.x, `BLOCK_X2_LO, `BLOCK_X2_HI)
		|| inRange(pixel.x, `BLOCK_X3_LO, `BLOCK_X3_HI);

	assign blockRow = inRange(pixel.y, `BLOCK_Y0_LO, `BLOCK_Y0_HI)
		|| inRange(pixel.y, `BLOCK_Y1_LO, `BLOCK_Y1_HI)
		|| inRange(pixel.y, `BLOCK_Y2_LO, `BLOCK_Y2_HI)
		|| inRange(pixel.y, `BLOCK_Y3_LO, `BLOCK_Y3_HI);

	////////////////////////////////////////
	// Colour rules

	assign red = hits[0].avatar || hits[1].avatar || hits[0].bomb || hits[0].blast;
	assign green = hits[1].avatar || wall || (blockCol && blockRow);
	assign blue = hits[0].bomb || hits[0].blast || hits[1].bomb || hits[1].blast;

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			vgaR <= 1'b0;
			vgaG <= 1'b0;
			vgaB <= 1'b0;
		end
		else
		begin
			vgaR <= red && pixel.active;
			vgaG <= green && pixel.active;
			vgaB <= blue && pixel.active;
		end
	end

endmodule

`default_nettype wire

// File: logic/playerUnit.sv
`default_nettype none
`include "bomb_macros.svh"

module playerUnit import bombPkg::*; #(
	parameter int playerIndex = 0
) (
	input wire logic DIV_CLK,
	input wire logic reset,
	input wire logic gameTick,
	input wire moveCmdT cmd,
	input wire pixelT pixel,
	output playerHitsT hits
);

	localparam coordT START_X = (playerIndex == 0) ? `P0_START_X : `P1_START_X;
	localparam coordT START_Y = (playerIndex == 0) ? `P0_START_Y : `P1_START_Y;

	localparam coordT KEEP_X_LO [4] = '{`KEEP_X0_LO, `KEEP_X1_LO, `KEEP_X2_LO, `KEEP_X3_LO};
	localparam coordT KEEP_X_HI [4] = '{`KEEP_X0_HI, `KEEP_X1_HI, `KEEP_X2_HI, `KEEP_X3_HI};
	localparam coordT KEEP_Y_LO [4] = '{`KEEP_Y0_LO, `KEEP_Y1_LO, `KEEP_Y2_LO, `KEEP_Y3_LO};
	localparam coordT KEEP_Y_HI [4] = '{`KEEP_Y0_HI, `KEEP_Y1_HI, `KEEP_Y2_HI, `KEEP_Y3_HI};

	localparam coordT SNAP_UP [4] = '{`SNAP_UP0, `SNAP_UP1, `SNAP_UP2, `SNAP_UP3};
	localparam coordT SNAP_DOWN [4] = '{`SNAP_DOWN0, `SNAP_DOWN1, `SNAP_DOWN2, `SNAP_DOWN3};
	localparam coordT SNAP_LEFT [4] = '{`SNAP_LEFT0, `SNAP_LEFT1, `SNAP_LEFT2, `SNAP_LEFT3};
	localparam coordT SNAP_RIGHT [4] = '{`SNAP_RIGHT0, `SNAP_RIGHT1, `SNAP_RIGHT2,
		`SNAP_RIGHT3};

	coordT posX;
	coordT posY;
	coordT movedX;
	coordT movedY;
	coordT nextX;
	coordT nextY;
	logic [3:0] colHit;
	logic [3:0] rowHit;
	logic [1:0] colIdx;
	logic [1:0] rowIdx;
	logic outOfArena;
	logic avatarHit;
	logic bombHit;
	logic blastHit;

	////////////////////////////////////////
	// Movement

	always_comb
	begin
		movedX = posX;
		movedY = posY;
		case (cmd.dir)
			UP:      movedY = posY - `STEP;
			DOWN:    movedY = posY + `STEP;
			LEFT:    movedX = posX - `STEP;
			RIGHT:   movedX = posX + `STEP;
			default: ;
		endcase
	end

	// Which keep-out column and row the moved point is in
	always_comb
	begin
		colIdx = '0;
		rowIdx = '0;
		for (int k = 0; k < 4; k++)
		begin
			colHit[k] = inOpen(movedX, KEEP_X_LO[k], KEEP_X_HI[k]);
			rowHit[k] = inOpen(movedY, KEEP_Y_LO[k], KEEP_Y_HI[k]);
			if (colHit[k])
				colIdx = 2'(k);
			if (rowHit[k])
				rowIdx = 2'(k);
		end
	end

	assign outOfArena = (posX < `ARENA_MIN_X) || (posX > `ARENA_MAX_X)
		|| (posY < `ARENA_MIN_Y) || (posY > `ARENA_MAX_Y);

	always_comb
	begin
		nextX = movedX;
		nextY = movedY;
		if (outOfArena)
		begin
			// Pull back inside, no move this tick
			nextX = posX;
			nextY = posY;
			if (posX < `ARENA_MIN_X)
				nextX = `ARENA_MIN_X;
			else if (posX > `ARENA_MAX_X)
				nextX = `ARENA_MAX_X;
			if (posY < `ARENA_MIN_Y)
				nextY = `ARENA_MIN_Y;
			else if (posY > `ARENA_MAX_Y)
				nextY = `ARENA_MAX_Y;
		end
		else if ((|colHit) && (|rowHit))
		begin
			case (cmd.dir)
				UP:      nextY = SNAP_UP[rowIdx];
				DOWN:    nextY = SNAP_DOWN[rowIdx];
				LEFT:    nextX = SNAP_LEFT[colIdx];
				RIGHT:   nextX = SNAP_RIGHT[colIdx];
				default: ;
			endcase
		end
	end

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			posX <= START_X;
			posY <= START_Y;
		end
		else if (gameTick)
		begin
			posX <= nextX;
			posY <= nextY;
		end
	end

	////////////////////////////////////////
	// Avatar square and bomb

	assign avatarHit = inRange(pixel.x, posX - `AVATAR_HALF, posX + `AVATAR_HALF)
		&& inRange(pixel.y, posY - `AVATAR_HALF, posY + `AVATAR_HALF);

	bombFuse bombFuse_i (
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.gameTick(gameTick),
		.dropBomb(cmd.dropBomb),
		.posX(posX),
		.posY(posY),
		.pixel(pixel),
		.bombHit(bombHit),
		.blastHit(blastHit)
	);

	assign hits = '{avatar: avatarHit, bomb: bombHit, blast: blastHit};

endmodule

`default_nettype wire

// File: logic/bombFuse.sv
`default_nettype none
`include "bomb_macros.svh"

module bombFuse import bombPkg::*; (
	input wire logic DIV_CLK,
	input wire logic reset,
	input wire logic gameTick,
	input wire logic dropBomb,
	input wire coordT posX,
	input wire coordT posY,
	input wire pixelT pixel,
	output logic bombHit,
	output logic blastHit
);

	localparam coordT ROW_LO [5] = '{`BAND_ROW0_LO, `BAND_ROW1_LO, `BAND_ROW2_LO,
		`BAND_ROW3_LO, `BAND_ROW4_LO};
	localparam coordT ROW_HI [5] = '{`BAND_ROW0_HI, `BAND_ROW1_HI, `BAND_ROW2_HI,
		`BAND_ROW3_HI, `BAND_ROW4_HI};
	localparam coordT ROW_DRAW_LO [5] = '{`BAND_ROW0_DRAW_LO, `BAND_ROW1_DRAW_LO,
		`BAND_ROW2_DRAW_LO, `BAND_ROW3_DRAW_LO, `BAND_ROW4_DRAW_LO};
	localparam coordT ROW_DRAW_HI [5] = '{`BAND_ROW0_DRAW_HI, `BAND_ROW1_DRAW_HI,
		`BAND_ROW2_DRAW_HI, `BAND_ROW3_DRAW_HI, `BAND_ROW4_DRAW_HI};
	localparam coordT COL_LO [5] = '{`BAND_COL0_LO, `BAND_COL1_LO, `BAND_COL2_LO,
		`BAND_COL3_LO, `BAND_COL4_LO};
	localparam coordT COL_HI [5] = '{`BAND_COL0_HI, `BAND_COL1_HI, `BAND_COL2_HI,
		`BAND_COL3_HI, `BAND_COL4_HI};
	localparam coordT COL_DRAW_LO [5] = '{`BAND_COL0_DRAW_LO, `BAND_COL1_DRAW_LO,
		`BAND_COL2_DRAW_LO, `BAND_COL3_DRAW_LO, `BAND_COL4_DRAW_LO};
	localparam coordT COL_DRAW_HI [5] = '{`BAND_COL0_DRAW_HI, `BAND_COL1_DRAW_HI,
		`BAND_COL2_DRAW_HI, `BAND_COL3_DRAW_HI, `BAND_COL4_DRAW_HI};

	fuseStateT state;
	tickCountT count;
	coordT bombX;
	coordT bombY;
	coordT distX;
	coordT distY;
	logic [20:0] distSq;
	logic bandHit;

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			count <= '0;
		end
		else if (gameTick)
		begin
			case (state)
				IDLE:
					if (dropBomb)
					begin
						state <= FUSE;
						count <= `FUSE_TICKS;
					end
				FUSE:
					if (count == tickCountT'(1))
					begin
						state <= BLAST;
						count <= `BLAST_TICKS;
					end
					else
						count <= count - tickCountT'(1);
				BLAST:
					if (count == tickCountT'(1))
					begin
						state <= IDLE;
						count <= '0;
					end
					else
						count <= count - tickCountT'(1);
				default:
					state <= IDLE;
			endcase
		end
	end

	// Drop point, captured on the accepting tick only
	always_ff @(posedge DIV_CLK)
	begin
		if (gameTick && state == IDLE && dropBomb)
		begin
			bombX <= posX;
			bombY <= posY;
		end
	end

	////////////////////////////////////////
	// Pixel tests

	assign distX = (pixel.x > bombX) ? pixel.x - bombX : bombX - pixel.x;
	assign distY = (pixel.y > bombY) ? pixel.y - bombY : bombY - pixel.y;
	assign distSq = distX * distX + distY * distY;

	// Blink with bit 3 of the fuse count
	assign bombHit = (state == FUSE) && !count[3]
		&& (distSq < `BOMB_RADIUS * `BOMB_RADIUS);

	always_comb
	begin
		bandHit = 1'b0;
		for (int k = 0; k < 5; k++)
		begin
			if (inRange(bombY, ROW_LO[k], ROW_HI[k])
					&& inRange(pixel.y, ROW_DRAW_LO[k], ROW_DRAW_HI[k])
					&& inRange(pixel.x, `BAND_ROW_X_LO, `BAND_ROW_X_HI))
				bandHit = 1'b1;
			if (inRange(bombX, COL_LO[k], COL_HI[k])
					&& inRange(pixel.x, COL_DRAW_LO[k], COL_DRAW_HI[k])
					&& inRange(pixel.y, `BAND_COL_Y_LO, `BAND_COL_Y_HI))
				bandHit = 1'b1;
		end
	end

	assign blastHit = (state == BLAST) && bandHit;

endmodule

`default_nettype wire

// File: logic/joystickDecoder.sv
`default_nettype none
`include "bomb_macros.svh"

module joystickDecoder import bombPkg::*; (
	input wire stickInT sticks [2],
	output moveCmdT cmds [2]
);

	for (genvar p = 0; p < 2; p++)
	begin : gPlayer
		logic xCentred;
		logic yCentred;
		moveCmdT cmd;

		// Neither axis past a threshold
		assign xCentred = (sticks[p].stickX >= `STICK_LOW) && (sticks[p].stickX <= `STICK_HIGH);
		assign yCentred = (sticks[p].stickY >= `STICK_LOW) && (sticks[p].stickY <= `STICK_HIGH);

		always_comb
		begin
			cmd.dropBomb = sticks[p].bombButton;
			// Diagonals give NONE
			if (sticks[p].stickY > `STICK_HIGH && xCentred)
				cmd.dir = UP;
			else if (sticks[p].stickY < `STICK_LOW && xCentred)
				cmd.dir = DOWN;
			else if (sticks[p].stickX < `STICK_LOW && yCentred)
				cmd.dir = LEFT;
			else if (sticks[p].stickX > `STICK_HIGH && yCentred)
				cmd.dir = RIGHT;
			else
				cmd.dir = NONE;
		end

		assign cmds[p] = cmd;
	end

endmodule

`default_nettype wire

// File: logic/bombPkg.sv
`default_nettype none
`include "bomb_macros.svh"

package bombPkg;

	typedef logic [`COORD_W-1:0] coordT;
	typedef logic [`STICK_W-1:0] stickT;
	typedef logic [`TICK_W-1:0] tickCountT;

	typedef enum logic [2:0] {UP, DOWN, LEFT, RIGHT, NONE} dirT;

	typedef enum logic [1:0] {IDLE, FUSE, BLAST} fuseStateT;

	typedef struct packed {
		stickT stickX;
		stickT stickY;
		logic bombButton;
	} stickInT;

	typedef struct packed {
		dirT dir;
		logic dropBomb;
	} moveCmdT;

	typedef struct packed {
		coordT x;
		coordT y;
		logic active;
	} pixelT;

	typedef struct packed {
		logic avatar;
		logic bomb;
		logic blast;
	} playerHitsT;

	// Closed interval test
	function automatic logic inRange(input coordT v, input coordT lo, input coordT hi);
		return (v >= lo) && (v <= hi);
	endfunction

	// Open interval, used for the keep-out areas
	function automatic logic inOpen(input coordT v, input coordT lo, input coordT hi);
		return (v > lo) && (v < hi);
	endfunction

endpackage

`default_nettype wire

// File: include/bomb_macros.svh
`ifndef BOMB_MACROS_SVH
`define BOMB_MACROS_SVH

`define COORD_W 10
`define STICK_W 10
`define TICK_W 7

////////////////////////////////////////
// Screen and arena
`define SCREEN_W 10'd640
`define SCREEN_H 10'd480
`define WALL_X 10'd5
`define WALL_Y 10'd6
`define ARENA_MIN_X 10'd26
`define ARENA_MAX_X 10'd614
`define ARENA_MIN_Y 10'd27
`define ARENA_MAX_Y 10'd453

////////////////////////////////////////
// Maze blocks as drawn
`define BLOCK_X0_LO 10'd75
`define BLOCK_X0_HI 10'd145
`define BLOCK_X1_LO 10'd215
`define BLOCK_X1_HI 10'd285
`define BLOCK_X2_LO 10'd355
`define BLOCK_X2_HI 10'd425
`define BLOCK_X3_LO 10'd495
`define BLOCK_X3_HI 10'd565
`define BLOCK_Y0_LO 10'd58
`define BLOCK_Y0_HI 10'd110
`define BLOCK_Y1_LO 10'd162
`define BLOCK_Y1_HI 10'd214
`define BLOCK_Y2_LO 10'd266
`define BLOCK_Y2_HI 10'd318
`define BLOCK_Y3_LO 10'd370
`define BLOCK_Y3_HI 10'd422

// Avatar centre keep-out, open intervals
`define KEEP_X0_LO 10'd55
`define KEEP_X0_HI 10'd165
`define KEEP_X1_LO 10'd195
`define KEEP_X1_HI 10'd305
`define KEEP_X2_LO 10'd335
`define KEEP_X2_HI 10'd445
`define KEEP_X3_LO 10'd475
`define KEEP_X3_HI 10'd585
`define KEEP_Y0_LO 10'd38
`define KEEP_Y0_HI 10'd130
`define KEEP_Y1_LO 10'd142
`define KEEP_Y1_HI 10'd234
`define KEEP_Y2_LO 10'd246
`define KEEP_Y2_HI 10'd338
`define KEEP_Y3_LO 10'd350
`define KEEP_Y3_HI 10'd442

// Where a blocked avatar ends up, per moving direction
`define SNAP_UP0 10'd131
`define SNAP_UP1 10'd235
`define SNAP_UP2 10'd339
`define SNAP_UP3 10'd443
`define SNAP_DOWN0 10'd37
`define SNAP_DOWN1 10'd141
`define SNAP_DOWN2 10'd245
`define SNAP_DOWN3 10'd349
`define SNAP_LEFT0 10'd166
`define SNAP_LEFT1 10'd306
`define SNAP_LEFT2 10'd446
`define SNAP_LEFT3 10'd586
`define SNAP_RIGHT0 10'd54
`define SNAP_RIGHT1 10'd194
`define SNAP_RIGHT2 10'd334
`define SNAP_RIGHT3 10'd474

////////////////////////////////////////
// Explosion bands, bomb range then drawn range
`define BAND_ROW0_LO 10'd6
`define BAND_ROW0_HI 10'd58
`define BAND_ROW0_DRAW_LO 10'd10
`define BAND_ROW0_DRAW_HI 10'd54
`define BAND_ROW1_LO 10'd110
`define BAND_ROW1_HI 10'd162
`define BAND_ROW1_DRAW_LO 10'd114
`define BAND_ROW1_DRAW_HI 10'd158
`define BAND_ROW2_LO 10'd214
`define BAND_ROW2_HI 10'd266
`define BAND_ROW2_DRAW_LO 10'd218
`define BAND_ROW2_DRAW_HI 10'd262
`define BAND_ROW3_LO 10'd318
`define BAND_ROW3_HI 10'd370
`define BAND_ROW3_DRAW_LO 10'd322
`define BAND_ROW3_DRAW_HI 10'd366
`define BAND_ROW4_LO 10'd422
`define BAND_ROW4_HI 10'd474
`define BAND_ROW4_DRAW_LO 10'd426
`define BAND_ROW4_DRAW_HI 10'd470
`define BAND_COL0_LO 10'd5
`define BAND_COL0_HI 10'd75
`define BAND_COL0_DRAW_LO 10'd9
`define BAND_COL0_DRAW_HI 10'd69
`define BAND_COL1_LO 10'd145
`define BAND_COL1_HI 10'd215
`define BAND_COL1_DRAW_LO 10'd149
`define BAND_COL1_DRAW_HI 10'd211
`define BAND_COL2_LO 10'd285
`define BAND_COL2_HI 10'd355
`define BAND_COL2_DRAW_LO 10'd289
`define BAND_COL2_DRAW_HI 10'd351
`define BAND_COL3_LO 10'd425
`define BAND_COL3_HI 10'd495
`define BAND_COL3_DRAW_LO 10'd429
`define BAND_COL3_DRAW_HI 10'd491
`define BAND_COL4_LO 10'd565
`define BAND_COL4_HI 10'd635
`define BAND_COL4_DRAW_LO 10'd569
`define BAND_COL4_DRAW_HI 10'd631
// Long extent shared by all bands
`define BAND_ROW_X_LO 10'd9
`define BAND_ROW_X_HI 10'd631
`define BAND_COL_Y_LO 10'd6
`define BAND_COL_Y_HI 10'd474

////////////////////////////////////////
// Game rules
`define STICK_LOW 10'd300
`define STICK_HIGH 10'd700
`define STEP 10'd3
`define FUSE_TICKS 7'd96
`define BLAST_TICKS 7'd24
`define AVATAR_HALF 10'd20
`define BOMB_RADIUS 10'd15
`define P0_START_X 10'd10
`define P0_START_Y 10'd10
`define P1_START_X 10'd600
`define P1_START_Y 10'd450

`endif
